// ==== verilog/dpc_pkg.sv ====
// dpc package: frame geometry, data widths, list depths and the bad-pixel list entry
package dpc_pkg;

    // ====================
    // frame geometry
    // ====================
    localparam int FRAME_WIDTH  = 16;   // pixels per line
    localparam int FRAME_HEIGHT = 8;    // lines per frame
    localparam int CNT_WIDTH    = 10;   // x/y coordinate width

    localparam int K_WIDTH = 16;        // per-pixel gain

    // ====================
    // bad-pixel tables
    // ====================
    localparam int MANUAL_BP_NUM = 8;
    localparam int MANUAL_BP_BIT = 3;
    localparam int AUTO_BP_NUM   = 16;
    localparam int AUTO_BP_BIT   = 4;

    // one table word, seen raw by software or split into coordinates
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [5:0]           pad_y;
            logic [CNT_WIDTH-1:0] y;
            logic [5:0]           pad_x;
            logic [CNT_WIDTH-1:0] x;
        } f;
    } bp_entry_u;

endpackage

// ==== verilog/k_window_if.sv ====
// k window bus: one clamped 3x3 k window with centre flag, neighbour flags and coordinates
interface k_window_if;

    logic                                 win_valid;      // one-cycle strobe
    logic [dpc_pkg::K_WIDTH-1:0]          centre_k;
    logic                                 centre_flag;
    logic [7:0][dpc_pkg::K_WIDTH-1:0]     nb_k;           // k11 k12 k13 k21 k23 k31 k32 k33
    logic [7:0]                           nb_flag;        // same order as nb_k
    logic [dpc_pkg::CNT_WIDTH-1:0]        x;
    logic [dpc_pkg::CNT_WIDTH-1:0]        y;
    logic                                 last_of_frame;

    modport source (output win_valid, centre_k, centre_flag, nb_k, nb_flag, x, y, last_of_frame);
    modport sink   (input  win_valid, centre_k, centre_flag, nb_k, nb_flag, x, y, last_of_frame);

endinterface

// ==== verilog/manual_bp_checker.sv ====
// manual bad-pixel checker: raster-ordered coordinate table matched against the input position
module manual_bp_checker (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic [dpc_pkg::CNT_WIDTH-1:0]      cur_x,
    input  logic [dpc_pkg::CNT_WIDTH-1:0]      cur_y,
    input  logic                               cur_valid,
    input  logic                               frame_start,
    input  logic [dpc_pkg::MANUAL_BP_BIT-1:0]  manual_bp_num,
    input  logic                               manual_wen,
    input  logic [dpc_pkg::MANUAL_BP_BIT-1:0]  manual_waddr,
    input  dpc_pkg::bp_entry_u                 manual_wdata,
    output logic                               manual_match
);

    dpc_pkg::bp_entry_u                bp_table [dpc_pkg::MANUAL_BP_NUM];
    dpc_pkg::bp_entry_u                next_bp;     // entry the pointer is waiting for
    logic [dpc_pkg::MANUAL_BP_BIT-1:0] rd_ptr;
    logic [dpc_pkg::MANUAL_BP_BIT-1:0] ptr_now;
    logic                              ptr_live;

    // software fills the table in raster order
    always_ff @(posedge aclk) begin
        if (manual_wen)
            bp_table[manual_waddr] <= manual_wdata;
    end

    // restart applies to the first sample of the frame itself
    assign ptr_now  = frame_start ? '0 : rd_ptr;
    assign next_bp  = bp_table[ptr_now];
    assign ptr_live = (ptr_now != manual_bp_num);   // table exhausted once equal

    assign manual_match = cur_valid && ptr_live &&
                          (next_bp.f.x == cur_x) && (next_bp.f.y == cur_y);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_ptr <= '0;
        end else if (manual_match) begin
            rd_ptr <= ptr_now + 1'b1;
        end else if (frame_start) begin
            rd_ptr <= '0;
        end
    end

endmodule

// ==== verilog/k_window_former.sv ====
// k window former: raster counters, two k line buffers, clamped 3x3 window and end-of-frame flush
module k_window_former (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          k_valid,
    input  logic [dpc_pkg::K_WIDTH-1:0]   k_data,
    input  logic                          manual_match,
    output logic [dpc_pkg::CNT_WIDTH-1:0] cur_x,
    output logic [dpc_pkg::CNT_WIDTH-1:0] cur_y,
    output logic                          cur_valid,
    output logic                          frame_start,
    k_window_if.source                    win
);

    logic [dpc_pkg::CNT_WIDTH-1:0]          x_last, y_last, y_flush;
    logic [$clog2(dpc_pkg::FRAME_WIDTH)-1:0] lb_addr;
    logic                                   flushing, step, emit;
    logic                                   last_in, last_flush;
    logic                                   win_valid_r, win_last;
    logic [dpc_pkg::K_WIDTH:0]              push_e, lb1_out, lb2_out;  // {flag, k}
    logic [dpc_pkg::K_WIDTH:0]              lb1 [dpc_pkg::FRAME_WIDTH];
    logic [dpc_pkg::K_WIDTH:0]              lb2 [dpc_pkg::FRAME_WIDTH];
    logic [2:0][2:0][dpc_pkg::K_WIDTH:0]    sr;      // [row][col], row 2 / col 2 newest
    logic [2:0][2:0][dpc_pkg::K_WIDTH:0]    row_c;   // after edge clamping
    logic [7:0][dpc_pkg::K_WIDTH:0]         nb_e;
    logic [dpc_pkg::CNT_WIDTH-1:0]          cen_x, cen_y;

    assign x_last  = dpc_pkg::CNT_WIDTH'(dpc_pkg::FRAME_WIDTH - 1);
    assign y_last  = dpc_pkg::CNT_WIDTH'(dpc_pkg::FRAME_HEIGHT - 1);
    assign y_flush = dpc_pkg::CNT_WIDTH'(dpc_pkg::FRAME_HEIGHT + 1);   // row of final flush step

    // ====================
    // step control
    // ====================
    assign cur_valid   = k_valid && !flushing;   // sender waits for frame_done
    assign frame_start = cur_valid && (cur_x == '0) && (cur_y == '0);
    assign step        = cur_valid || flushing;
    assign last_in     = cur_valid && (cur_x == x_last) && (cur_y == y_last);
    assign last_flush  = flushing && (cur_x == '0) && (cur_y == y_flush);
    assign emit        = (cur_y > 1) || ((cur_y == 1) && (cur_x != '0)); // centre lags W+1 steps

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cur_x       <= '0;
            cur_y       <= '0;
            flushing    <= 1'b0;
            win_valid_r <= 1'b0;
            win_last    <= 1'b0;
        end else begin
            win_valid_r <= step && emit;
            win_last    <= last_flush;
            if (step) begin
                if (last_flush) begin
                    cur_x <= '0;
                    cur_y <= '0;
                end else if (cur_x == x_last) begin
                    cur_x <= '0;
                    cur_y <= cur_y + 1'b1;
                end else begin
                    cur_x <= cur_x + 1'b1;
                end
            end
            if (last_in)
                flushing <= 1'b1;
            else if (last_flush)
                flushing <= 1'b0;
        end
    end

    // ====================
    // line buffers, window
    // ====================
    assign lb_addr = cur_x[$clog2(dpc_pkg::FRAME_WIDTH)-1:0];
    assign lb1_out = lb1[lb_addr];   // one line back
    assign lb2_out = lb2[lb_addr];   // two lines back
    // flush copies the line above, it is clamped away anyway
    assign push_e  = flushing ? lb1_out : {manual_match || (k_data == '0), k_data};

    always_ff @(posedge aclk) begin
        if (step) begin
            lb1[lb_addr] <= push_e;
            lb2[lb_addr] <= lb1_out;
            for (int r = 0; r < 3; r++) begin
                sr[r][0] <= sr[r][1];
                sr[r][1] <= sr[r][2];
            end
            sr[0][2] <= lb2_out;
            sr[1][2] <= lb1_out;
            sr[2][2] <= push_e;
            if (cur_x == '0) begin   // centre sits on the previous line's end
                cen_x <= x_last;
                cen_y <= cur_y - 2'd2;
            end else begin
                cen_x <= cur_x - 1'b1;
                cen_y <= cur_y - 1'b1;
            end
        end
    end

    // edge clamp, columns first so corners fall back onto the centre
    always_comb begin
        row_c = sr;
        for (int r = 0; r < 3; r++) begin
            if (cen_x == '0)
                row_c[r][0] = sr[r][1];
            if (cen_x == x_last)
                row_c[r][2] = sr[r][1];
        end
        if (cen_y == '0)
            row_c[0] = row_c[1];
        if (cen_y == y_last)
            row_c[2] = row_c[1];
    end

    assign nb_e = {row_c[2][2], row_c[2][1], row_c[2][0], row_c[1][2],
                   row_c[1][0], row_c[0][2], row_c[0][1], row_c[0][0]};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            win.nb_k[i]    = nb_e[i][dpc_pkg::K_WIDTH-1:0];
            win.nb_flag[i] = nb_e[i][dpc_pkg::K_WIDTH];
        end
    end

    assign win.win_valid     = win_valid_r;
    assign win.centre_k      = row_c[1][1][dpc_pkg::K_WIDTH-1:0];
    assign win.centre_flag   = row_c[1][1][dpc_pkg::K_WIDTH];
    assign win.x             = cen_x;
    assign win.y             = cen_y;
    assign win.last_of_frame = win_last;

endmodule

// ==== verilog/neighbor_median.sv ====
// neighbour median: compacts unflagged neighbours, sorts them and picks the lower median
module neighbor_median (
    input  logic                          aclk,
    input  logic                          aresetn,
    k_window_if.sink                      win,
    output logic                          med_valid,
    output logic [dpc_pkg::K_WIDTH-1:0]   centre_k,
    output logic                          centre_flag,
    output logic [dpc_pkg::K_WIDTH-1:0]   median_k,
    output logic [3:0]                    nb_count,
    output logic [dpc_pkg::CNT_WIDTH-1:0] med_x,
    output logic [dpc_pkg::CNT_WIDTH-1:0] med_y,
    output logic                          med_last
);

    logic [7:0][dpc_pkg::K_WIDTH-1:0]                     pack_c, sort_c;
    logic [7:0][dpc_pkg::K_WIDTH-1:0]                     s1_vals, s2_vals;
    logic [3:0]                                           cnt_c, s1_cnt, s2_cnt, mid_idx;
    logic                                                 s1_valid, s2_valid;
    logic [dpc_pkg::K_WIDTH+2*dpc_pkg::CNT_WIDTH+1:0]     s1_ctr, s2_ctr; // centre side info

    // stage 1: unflagged neighbours into the low slots
    always_comb begin
        pack_c = '1;    // empty slots sort to the top
        cnt_c  = '0;
        for (int i = 0; i < 8; i++) begin
            if (!win.nb_flag[i]) begin
                pack_c[cnt_c[2:0]] = win.nb_k[i];
                cnt_c = cnt_c + 1'b1;
            end
        end
    end

    // stage 2: odd-even transposition sort, ascending
    always_comb begin
        sort_c = s1_vals;
        for (int p = 0; p < 8; p++) begin
            for (int i = p % 2; i < 7; i += 2) begin
                if (sort_c[i] > sort_c[i+1])
                    {sort_c[i], sort_c[i+1]} = {sort_c[i+1], sort_c[i]};
            end
        end
    end

    // stage 3 index, (count-1)/2
    assign mid_idx = (s2_cnt - 1'b1) >> 1;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            med_valid <= 1'b0;
        end else begin
            s1_valid  <= win.win_valid;
            s2_valid  <= s1_valid;
            med_valid <= s2_valid;
        end
    end

    always_ff @(posedge aclk) begin
        s1_vals  <= pack_c;
        s1_cnt   <= cnt_c;
        s1_ctr   <= {win.centre_k, win.centre_flag, win.x, win.y, win.last_of_frame};
        s2_vals  <= sort_c;
        s2_cnt   <= s1_cnt;
        s2_ctr   <= s1_ctr;
        median_k <= s2_vals[mid_idx[2:0]];   // don't care when count is zero
        nb_count <= s2_cnt;
        {centre_k, centre_flag, med_x, med_y, med_last} <= s2_ctr;
    end

endmodule

// ==== verilog/bp_list_recorder.sv ====
// bad-pixel recorder: deviation test, report pulse, auto list RAM with count and readback
module bp_list_recorder (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             med_valid,
    input  logic [dpc_pkg::K_WIDTH-1:0]      centre_k,
    input  logic                             centre_flag,
    input  logic [dpc_pkg::K_WIDTH-1:0]      median_k,
    input  logic [3:0]                       nb_count,
    input  logic [dpc_pkg::CNT_WIDTH-1:0]    med_x,
    input  logic [dpc_pkg::CNT_WIDTH-1:0]    med_y,
    input  logic                             med_last,
    input  logic [dpc_pkg::K_WIDTH-1:0]      k_threshold,
    output logic                             auto_bp_valid,
    output logic [dpc_pkg::CNT_WIDTH-1:0]    auto_bp_x,
    output logic [dpc_pkg::CNT_WIDTH-1:0]    auto_bp_y,
    input  logic [dpc_pkg::AUTO_BP_BIT-1:0]  auto_bp_read_addr,
    output dpc_pkg::bp_entry_u               auto_bp_read_data,
    output logic [dpc_pkg::AUTO_BP_BIT:0]    detected_bp_count,
    output logic                             frame_done
);

    dpc_pkg::bp_entry_u                list_mem [dpc_pkg::AUTO_BP_NUM];
    dpc_pkg::bp_entry_u                new_entry;
    logic [dpc_pkg::K_WIDTH-1:0]       abs_dev;
    logic [dpc_pkg::AUTO_BP_BIT:0]     count_base;
    logic                              is_bad, frame_first, list_wen;

    assign abs_dev     = (centre_k > median_k) ? centre_k - median_k : median_k - centre_k;
    assign is_bad      = centre_flag || ((nb_count != '0) && (abs_dev > k_threshold));
    assign frame_first = med_valid && (med_x == '0) && (med_y == '0);
    assign count_base  = frame_first ? '0 : detected_bp_count;     // new frame starts empty
    assign list_wen    = med_valid && is_bad && !count_base[dpc_pkg::AUTO_BP_BIT]; // msb = full

    always_comb begin
        new_entry.f.pad_y = '0;
        new_entry.f.y     = med_y;
        new_entry.f.pad_x = '0;
        new_entry.f.x     = med_x;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            auto_bp_valid     <= 1'b0;
            frame_done        <= 1'b0;
            detected_bp_count <= '0;
        end else begin
            auto_bp_valid <= med_valid && is_bad;   // keeps reporting after the list is full
            frame_done    <= med_valid && med_last;
            if (list_wen)
                detected_bp_count <= count_base + 1'b1;
            else if (frame_first)
                detected_bp_count <= '0;
        end
    end

    always_ff @(posedge aclk) begin
        auto_bp_x <= med_x;
        auto_bp_y <= med_y;
        if (list_wen)
            list_mem[count_base[dpc_pkg::AUTO_BP_BIT-1:0]] <= new_entry;
        if ({1'b0, auto_bp_read_addr} < detected_bp_count)
            auto_bp_read_data <= list_mem[auto_bp_read_addr];
        else
            auto_bp_read_data.word <= '0;   // past the count
    end

endmodule

// ==== verilog/dpc_detector.sv ====
// dpc detector top: k-stream bad-pixel detection with manual table and auto list readback
module dpc_detector (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               k_valid,
    input  logic [dpc_pkg::K_WIDTH-1:0]        k_data,
    input  logic [dpc_pkg::K_WIDTH-1:0]        k_threshold,
    input  logic [dpc_pkg::MANUAL_BP_BIT-1:0]  manual_bp_num,
    input  logic                               manual_wen,
    input  logic [dpc_pkg::MANUAL_BP_BIT-1:0]  manual_waddr,
    input  dpc_pkg::bp_entry_u                 manual_wdata,
    output logic                               auto_bp_valid,
    output logic [dpc_pkg::CNT_WIDTH-1:0]      auto_bp_x,
    output logic [dpc_pkg::CNT_WIDTH-1:0]      auto_bp_y,
    input  logic [dpc_pkg::AUTO_BP_BIT-1:0]    auto_bp_read_addr,
    output dpc_pkg::bp_entry_u                 auto_bp_read_data,
    output logic [dpc_pkg::AUTO_BP_BIT:0]      detected_bp_count,
    output logic                               frame_done
);

    logic [dpc_pkg::CNT_WIDTH-1:0] cur_x, cur_y, med_x, med_y;
    logic [dpc_pkg::K_WIDTH-1:0]   centre_k, median_k;
    logic [3:0]                    nb_count;
    logic                          cur_valid, frame_start, manual_match;
    logic                          med_valid, centre_flag, med_last;

    k_window_if win_bus ();

    manual_bp_checker i_manual (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cur_x         (cur_x),
        .cur_y         (cur_y),
        .cur_valid     (cur_valid),
        .frame_start   (frame_start),
        .manual_bp_num (manual_bp_num),
        .manual_wen    (manual_wen),
        .manual_waddr  (manual_waddr),
        .manual_wdata  (manual_wdata),
        .manual_match  (manual_match)
    );

    k_window_former i_former (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .k_valid      (k_valid),
        .k_data       (k_data),
        .manual_match (manual_match),
        .cur_x        (cur_x),
        .cur_y        (cur_y),
        .cur_valid    (cur_valid),
        .frame_start  (frame_start),
        .win          (win_bus.source)
    );

    neighbor_median i_median (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .win         (win_bus.sink),
        .med_valid   (med_valid),
        .centre_k    (centre_k),
        .centre_flag (centre_flag),
        .median_k    (median_k),
        .nb_count    (nb_count),
        .med_x       (med_x),
        .med_y       (med_y),
        .med_last    (med_last)
    );

    bp_list_recorder i_recorder (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .med_valid         (med_valid),
        .centre_k          (centre_k),
        .centre_flag       (centre_flag),
        .median_k          (median_k),
        .nb_count          (nb_count),
        .med_x             (med_x),
        .med_y             (med_y),
        .med_last          (med_last),
        .k_threshold       (k_threshold),
        .auto_bp_valid     (auto_bp_valid),
        .auto_bp_x         (auto_bp_x),
        .auto_bp_y         (auto_bp_y),
        .auto_bp_read_addr (auto_bp_read_addr),
        .auto_bp_read_data (auto_bp_read_data),
        .detected_bp_count (detected_bp_count),
        .frame_done        (frame_done)
    );

endmodule

// ==== tb/dpc_detector_props.sv ====
// dpc detector properties: reports inside the frame, bounded list count, quiet outputs after reset
module dpc_detector_props (
    input logic                              aclk,
    input logic                              aresetn,
    input logic                              auto_bp_valid,
    input logic                              frame_done,
    input logic [dpc_pkg::CNT_WIDTH-1:0]     auto_bp_x,
    input logic [dpc_pkg::CNT_WIDTH-1:0]     auto_bp_y,
    input logic [dpc_pkg::AUTO_BP_BIT:0]     detected_bp_count
);
    timeunit 1ns;
    timeprecision 100ps;

    report_in_frame: assert property (@(posedge aclk) disable iff (!aresetn)
        auto_bp_valid |-> (auto_bp_x < dpc_pkg::CNT_WIDTH'(dpc_pkg::FRAME_WIDTH)) &&
                          (auto_bp_y < dpc_pkg::CNT_WIDTH'(dpc_pkg::FRAME_HEIGHT)))
        else $error("bad-pixel report with coordinates outside the frame");

    count_bounded: assert property (@(posedge aclk) disable iff (!aresetn)
        detected_bp_count <= (dpc_pkg::AUTO_BP_BIT + 1)'(dpc_pkg::AUTO_BP_NUM))
        else $error("auto list count above the list depth");

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge aclk)
        $rose(aresetn) |-> !auto_bp_valid && !frame_done)
        else $error("report or frame_done high right after reset");

endmodule

// ==== tb/tb_dpc_detector.sv ====
// dpc detector testbench checking directed frames against a clamped-window median model
module tb_dpc_detector;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int W         = dpc_pkg::FRAME_WIDTH;
    localparam int H         = dpc_pkg::FRAME_HEIGHT;
    localparam int NUM_TESTS = 5;
    localparam int LIMIT     = NUM_TESTS * (W * H + W + 20) * 2;   // cycles

    logic                              aclk, aresetn, k_valid, manual_wen;
    logic [dpc_pkg::K_WIDTH-1:0]       k_data, k_threshold;
    logic [dpc_pkg::MANUAL_BP_BIT-1:0] manual_bp_num, manual_waddr;
    dpc_pkg::bp_entry_u                manual_wdata, auto_bp_read_data;
    logic                              auto_bp_valid, frame_done;
    logic [dpc_pkg::CNT_WIDTH-1:0]     auto_bp_x, auto_bp_y;
    logic [dpc_pkg::AUTO_BP_BIT-1:0]   auto_bp_read_addr;
    logic [dpc_pkg::AUTO_BP_BIT:0]     detected_bp_count;

    logic [dpc_pkg::K_WIDTH-1:0] frame_k [H][W];   // [y][x]
    bit                          man_flag [H][W];
    dpc_pkg::bp_entry_u          exp_q [$];         // model reports in raster order
    dpc_pkg::bp_entry_u          rep_q [$];         // seen on auto_bp_*
    int                          frames_seen, cycles;

    dpc_detector i_dut (.*);

    bind dpc_detector dpc_detector_props i_props (
        .aclk (aclk), .aresetn (aresetn), .auto_bp_valid (auto_bp_valid),
        .frame_done (frame_done), .auto_bp_x (auto_bp_x), .auto_bp_y (auto_bp_y),
        .detected_bp_count (detected_bp_count)
    );

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles++;
        if (cycles > LIMIT)
            stop_run("timeout: the tests did not finish within the cycle limit");
    end

    // outputs settle after the rising edge
    always @(negedge aclk) begin
        if (aresetn && auto_bp_valid)
            rep_q.push_back(make_entry(auto_bp_x, auto_bp_y));
        if (aresetn && frame_done)
            frames_seen++;
    end

    // ====================
    // checks
    // ====================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_coord(input string what, input logic [dpc_pkg::CNT_WIDTH-1:0] got,
                               input logic [dpc_pkg::CNT_WIDTH-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            stop_run($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_entry(input string what, input dpc_pkg::bp_entry_u got,
                               input dpc_pkg::bp_entry_u exp);
        if (got.word !== exp.word)
            stop_run($sformatf("error at %0t ns: %s is %h (x %0d y %0d), expected %h",
                               $time, what, got.word, got.f.x, got.f.y, exp.word));
    endtask

    // ====================
    // reference model
    // ====================
    function automatic dpc_pkg::bp_entry_u make_entry(input logic [dpc_pkg::CNT_WIDTH-1:0] x,
                                                      input logic [dpc_pkg::CNT_WIDTH-1:0] y);
        dpc_pkg::bp_entry_u e;
        e.word = '0;
        e.f.x  = x;
        e.f.y  = y;
        return e;
    endfunction

    function automatic int clamp(input int v, input int hi);
        if (v < 0)
            return 0;
        if (v > hi)
            return hi;
        return v;
    endfunction

    function automatic bit is_flagged(input int x, input int y);
        return (frame_k[y][x] == '0) || man_flag[y][x];   // dead or listed
    endfunction

    function automatic bit pixel_bad(input int x, input int y);
        int vals [8];
        int n, cx, cy, t, med, dev;
        n = 0;
        if (is_flagged(x, y))
            return 1'b1;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                cx = clamp(x + dx, W - 1);   // edge neighbours fold inward
                cy = clamp(y + dy, H - 1);
                if (!(dx == 0 && dy == 0) && !is_flagged(cx, cy)) begin
                    vals[n] = int'(frame_k[cy][cx]);
                    n++;
                end
            end
        end
        if (n == 0)
            return 1'b0;
        for (int i = 1; i < n; i++) begin
            for (int j = i; j > 0 && vals[j-1] > vals[j]; j--) begin
                t         = vals[j];
                vals[j]   = vals[j-1];
                vals[j-1] = t;
            end
        end
        med = vals[(n - 1) / 2];   // lower median
        dev = int'(frame_k[y][x]) - med;
        if (dev < 0)
            dev = -dev;
        return dev > int'(k_threshold);
    endfunction

    function automatic void build_expected();
        exp_q.delete();
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                if (pixel_bad(x, y))
                    exp_q.push_back(make_entry(dpc_pkg::CNT_WIDTH'(x), dpc_pkg::CNT_WIDTH'(y)));
    endfunction

    // ====================
    // stimulus
    // ====================
    function automatic void fill_frame(input int base, input int sx, input int sy);
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                frame_k[y][x]  = dpc_pkg::K_WIDTH'(base + sx * x + sy * y);
                man_flag[y][x] = 1'b0;
            end
        end
    endfunction

    task automatic write_manual(input int idx, input int x, input int y);
        @(negedge aclk);
        manual_wen     = 1'b1;
        manual_waddr   = dpc_pkg::MANUAL_BP_BIT'(idx);
        manual_wdata   = make_entry(dpc_pkg::CNT_WIDTH'(x), dpc_pkg::CNT_WIDTH'(y));
        man_flag[y][x] = 1'b1;
        @(negedge aclk);
        manual_wen     = 1'b0;
    endtask

    task automatic check_readback();
        dpc_pkg::bp_entry_u want;
        for (int a = 0; a < dpc_pkg::AUTO_BP_NUM; a++) begin
            @(negedge aclk);
            auto_bp_read_addr = dpc_pkg::AUTO_BP_BIT'(a);
            @(negedge aclk);   // one cycle read latency
            want.word = '0;    // zero past the count
            if (a < exp_q.size())
                want = exp_q[a];
            check_entry($sformatf("auto list word %0d", a), auto_bp_read_data, want);
        end
    endtask

    // streams frame_k, waits for frame_done, checks reports, count and list
    task automatic run_frame(input bit gaps);
        int start;
        start = frames_seen;
        build_expected();
        rep_q.delete();
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                if (gaps && $urandom_range(3, 0) == 0) begin
                    @(negedge aclk);
                    k_valid = 1'b0;
                end
                @(negedge aclk);
                k_valid = 1'b1;
                k_data  = frame_k[y][x];
            end
        end
        @(negedge aclk);
        k_valid = 1'b0;
        while (frames_seen == start)
            @(posedge aclk);
        repeat (3) @(negedge aclk);
        check_count("frame_done pulses", frames_seen - start, 1);
        check_count("report count", rep_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            check_coord($sformatf("report %0d x", i), rep_q[i].f.x, exp_q[i].f.x);
            check_coord($sformatf("report %0d y", i), rep_q[i].f.y, exp_q[i].f.y);
        end
        check_count("detected_bp_count", int'(detected_bp_count),
                    (exp_q.size() < dpc_pkg::AUTO_BP_NUM) ? exp_q.size() : dpc_pkg::AUTO_BP_NUM);
        check_readback();
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_uniform();
        k_threshold   = 16'd10;
        manual_bp_num = '0;
        fill_frame(1000, 0, 0);
        run_frame(1'b0);
    endtask

    task automatic test_dead_and_outliers();
        k_threshold   = 16'd30;
        manual_bp_num = '0;
        fill_frame(1000, 10, 5);   // ramp exercises the clamped edges
        frame_k[0][0]  = '0;
        frame_k[0][15] = '0;
        frame_k[7][0]  = '0;
        frame_k[7][15] = '0;
        frame_k[0][7]  = '0;
        frame_k[4][0]  = '0;
        frame_k[3][15] = 16'd1500;
        frame_k[7][8]  = 16'd500;
        frame_k[5][5]  = 16'd1200;
        run_frame(1'b1);
    endtask

    task automatic test_manual_and_dead_neighbour();
        k_threshold   = 16'd20;
        fill_frame(1000, 0, 0);
        write_manual(0, 2, 1);
        write_manual(1, 9, 4);
        write_manual(2, 15, 7);
        manual_bp_num = 3'd3;
        frame_k[2][4]  = '0;   // half of (5,3)'s neighbours dead
        frame_k[2][5]  = '0;
        frame_k[2][6]  = '0;
        frame_k[3][4]  = '0;
        frame_k[5][12] = 16'd1040;
        frame_k[5][13] = '0;
        run_frame(1'b0);
    endtask

    task automatic test_list_saturation();
        k_threshold   = 16'd50;
        manual_bp_num = '0;
        fill_frame(0, 0, 0);
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                frame_k[y][x] = dpc_pkg::K_WIDTH'($urandom_range(4000, 0));
        run_frame(1'b1);
        if (rep_q.size() <= dpc_pkg::AUTO_BP_NUM)
            stop_run("reporting did not go on once the auto list was full");
    endtask

    task automatic test_next_frame();
        k_threshold   = 16'd20;
        manual_bp_num = '0;
        fill_frame(2000, 0, 0);
        frame_k[2][3]  = '0;
        frame_k[6][11] = 16'd2100;
        run_frame(1'b0);
    endtask

    initial begin
        void'($urandom(32'hd6915dca));
        aresetn           = 1'b0;
        k_valid           = 1'b0;
        k_data            = '0;
        k_threshold       = '0;
        manual_bp_num     = '0;
        manual_wen        = 1'b0;
        manual_waddr      = '0;
        manual_wdata      = '0;
        auto_bp_read_addr = '0;
        repeat (10) @(negedge aclk);
        aresetn = 1'b1;
        test_uniform();
        test_dead_and_outliers();
        test_manual_and_dead_neighbour();
        test_list_saturation();
        test_next_frame();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/dpc_pkg.sv
verilog/k_window_if.sv
verilog/manual_bp_checker.sv
verilog/k_window_former.sv
verilog/neighbor_median.sv
verilog/bp_list_recorder.sv
verilog/dpc_detector.sv
tb/dpc_detector_props.sv
tb/tb_dpc_detector.sv

// ==== Makefile ====
# Verilator build and run for the dpc detector testbench
VERILATOR ?= verilator
TOP       ?= tb_dpc_detector
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
